/* rename_top.f */
+incdir+tb
common/rename_pkg.sv
src/retire_queue.sv
rename/free_list.sv
rename/map_table.sv
rename/rename_stage.sv
src/rename_top.sv
tb/rename_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module rename_tb -f rename_top.f -o rename_sim
./obj_dir/rename_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi

/* tb/rename_cases.svh */
`ifndef RENAME_CASES_SVH
`define RENAME_CASES_SVH

// Columns: op, has_dest, is_branch, rs1, rs2, rd, expected stall, repeat count
// Register columns are ignored on random and retire rows
task automatic load_cases;
	// First renames after reset take 32, 33, 34
	add_row(op_disp, 1, 0, 0, 0, 1, 0, 1);
	add_row(op_disp, 1, 0, 1, 1, 2, 0, 1);  // Reads the new x1
	add_row(op_disp, 1, 0, 2, 1, 3, 0, 1);
	add_row(op_disp, 0, 0, 3, 2, 0, 0, 1);  // No dest, prd stays 0
	add_row(op_disp, 1, 0, 1, 3, 1, 0, 1);  // Second write to x1
	add_row(op_ret,  0, 0, 0, 0, 0, 0, 5);
	// Empty the free list with no retires
	add_row(op_rand, 1, 0, 0, 0, 0, 0, 32);
	add_row(op_disp, 0, 0, 4, 5, 0, 0, 1);  // No dest passes an empty list
	add_row(op_disp, 1, 0, 6, 7, 8, 1, 1);  // Held until a retire frees one
	add_row(op_ret,  0, 0, 0, 0, 0, 0, 10);
	add_row(op_rand, 1, 0, 0, 0, 0, 0, 8);
	// Branch, then wrong-path writes
	add_row(op_disp, 0, 1, 8, 1, 0, 0, 1);
	add_row(op_disp, 1, 0, 8, 2, 8, 0, 1);
	add_row(op_disp, 1, 0, 1, 1, 1, 0, 1);
	add_row(op_ret,  0, 0, 0, 0, 0, 0, 31); // Up to the branch
	add_row(op_misp, 0, 0, 0, 0, 0, 0, 1);
	// Renames resume from the retired maps
	add_row(op_disp, 1, 0, 8, 1, 2, 0, 1);
	add_row(op_disp, 1, 0, 2, 3, 9, 0, 1);
	add_row(op_rand, 1, 0, 0, 0, 0, 0, 12);
	add_row(op_ret,  0, 0, 0, 0, 0, 0, 6);
	add_row(op_rand, 0, 0, 0, 0, 0, 0, 4);
	add_row(op_rand, 1, 0, 0, 0, 0, 0, 6);
endtask

`endif

/* tb/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

	import rename_pkg::*;

	localparam int rq_depth   = 64;  // Only the free list can stall
	localparam int op_disp    = 0;   // Fixed registers
	localparam int op_rand    = 1;   // Repeated dispatches with random registers
	localparam int op_ret     = 2;   // Repeated plain retires
	localparam int op_misp    = 3;   // Mispredicted branch retire
	localparam int wait_limit = 200;

	typedef struct packed {
		logic [1:0] op;
		logic       has_dest;
		logic       is_branch;
		arch_reg_t  rs1;
		arch_reg_t  rs2;
		arch_reg_t  rd;
		logic       exp_stall;
		logic [7:0] reps;
	} case_row_t;

	logic          clock, reset, retire, retire_mispredict, stall, rq_empty;
	rename_in_t    dispatch;
	rename_out_t   renamed;
	fl_count_t     num_free;

	phys_reg_t     spec_map [num_arch_reg];  // Model maps
	phys_reg_t     ret_map  [num_arch_reg];
	phys_reg_t     spec_fl [$];              // Model free lists
	phys_reg_t     ck_fl [$];
	retire_entry_t model_rq [$];
	rename_out_t   exp_out;                  // Expected on renamed after the edge
	case_row_t     cases [$];
	logic [31:0]   rng_state;
	int            mismatch_count, other_count;

	rename_top #(.rq_depth(rq_depth)) UUT (
		.clock, .reset, .dispatch, .retire, .retire_mispredict,
		.stall, .renamed, .num_free, .rq_empty
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic add_row(input int op, input int has_dest, input int is_branch,
		input int rs1, input int rs2, input int rd, input int exp_stall, input int reps);
		case_row_t r;
		r.op        = op[1:0];
		r.has_dest  = has_dest[0];
		r.is_branch = is_branch[0];
		r.rs1       = arch_reg_t'(rs1);
		r.rs2       = arch_reg_t'(rs2);
		r.rd        = arch_reg_t'(rd);
		r.exp_stall = exp_stall[0];
		r.reps      = 8'(reps);
		cases.push_back(r);
	endtask

	`include "rename_cases.svh"

	task automatic check_renamed(input rename_out_t got, input rename_out_t exp);
		if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
			mismatch_count++;
			$display("Mismatch renamed: got v%h d%h %h %h %h %h, expected v%h d%h %h %h %h %h",
				got.valid, got.has_dest, got.prs1, got.prs2, got.prd, got.prd_old,
				exp.valid, exp.has_dest, exp.prs1, exp.prs2, exp.prd, exp.prd_old);
		end
	endtask

	task automatic check_level(input string name, input fl_count_t got, input fl_count_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// One cycle and a compare of the registered results
	task automatic tick;
		@(posedge clock);
		@(negedge clock);
		check_renamed(renamed, exp_out);
		check_level("num_free", num_free, fl_count_t'(spec_fl.size()));
		check_level("rq_empty", fl_count_t'(rq_empty), fl_count_t'(model_rq.size() == 0));
		exp_out.valid = 1'b0; // Idle unless the next op renames
	endtask

	task automatic model_dispatch(input rename_in_t d);
		retire_entry_t e;
		exp_out          = '0;
		exp_out.valid    = 1'b1;
		exp_out.has_dest = d.has_dest;
		exp_out.prs1     = spec_map[d.rs1];
		exp_out.prs2     = spec_map[d.rs2];
		if (d.has_dest) begin
			exp_out.prd     = spec_fl.pop_front();  // Head of free list
			exp_out.prd_old = spec_map[d.rd];
			spec_map[d.rd]  = exp_out.prd;
		end
		e.has_dest = d.has_dest;
		e.rd       = d.rd;
		e.prd      = exp_out.prd;
		e.prd_old  = exp_out.prd_old;
		model_rq.push_back(e);
	endtask

	task automatic model_retire(input logic mispredict);
		retire_entry_t e;
		e = model_rq.pop_front();
		if (e.has_dest) begin
			spec_fl.push_back(e.prd_old);   // T_old back to the tail
			void'(ck_fl.pop_front());       // Checkpoint gives up T_new
			ck_fl.push_back(e.prd_old);
			ret_map[e.rd] = e.prd;
		end
		if (mispredict) begin
			spec_map = ret_map;
			spec_fl  = ck_fl;
			model_rq.delete();
		end
	endtask

	task automatic run_retire(input logic mispredict);
		if (model_rq.size() == 0) begin
			other_count++;
			$display("Retire requested while the retire queue is empty");
		end else begin
			retire            = 1'b1;
			retire_mispredict = mispredict;
			model_retire(mispredict);
			tick();
			retire            = 1'b0;
			retire_mispredict = 1'b0;
		end
	endtask

	task automatic run_dispatch(input rename_in_t d, input logic exp_stall);
		logic model_stall;
		int   waited;
		model_stall = (d.has_dest && spec_fl.size() == 0) || model_rq.size() == rq_depth;
		dispatch = d;
		if (model_stall) begin
			retire = 1'b1; // Frees a register while the instruction waits
			model_retire(1'b0);
		end
		#1; // Let stall settle
		if (model_stall != exp_stall) begin
			other_count++;
			$display("Stall column disagrees with the reference model at %0t", $time);
		end
		check_level("stall", fl_count_t'(stall), fl_count_t'(exp_stall));
		if (model_stall) begin
			tick();
			retire = 1'b0;
			waited = 0;
			while (stall && waited < wait_limit) begin
				tick();
				waited++;
			end
			if (stall) begin
				other_count++;
				$display("Timed out waiting for stall to drop");
			end
		end
		model_dispatch(d);
		tick();
		dispatch.valid = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		case_row_t  row;
		rename_in_t d;
		int         waited;
		reset             = 1'b1;
		dispatch          = '0;
		retire            = 1'b0;
		retire_mispredict = 1'b0;
		rng_state         = 32'h1848c622;
		exp_out           = '0;
		mismatch_count    = 0;
		other_count       = 0;
		for (int i = 0; i < num_arch_reg; i++) begin
			spec_map[i] = phys_reg_t'(i); // Identity after reset
			ret_map[i]  = phys_reg_t'(i);
		end
		for (int i = 0; i < fl_size; i++)
			spec_fl.push_back(phys_reg_t'(num_arch_reg + i));
		ck_fl = spec_fl;
		load_cases();
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		tick();   // Reset values
		check_level("stall", fl_count_t'(stall), '0);
		foreach (cases[n]) begin
			row = cases[n];
			case (int'(row.op))
				op_disp, op_rand: begin
					repeat (row.reps) begin
						d           = '0;
						d.valid     = 1'b1;
						d.has_dest  = row.has_dest;
						d.is_branch = row.is_branch;
						d.rs1       = row.rs1;
						d.rs2       = row.rs2;
						d.rd        = row.rd;
						if (int'(row.op) == op_rand) begin
							rng_state = xorshift32(rng_state);
							d.rs1     = rng_state[4:0];
							d.rs2     = rng_state[9:5];
							d.rd      = rng_state[14:10];
						end
						run_dispatch(d, row.exp_stall);
					end
				end
				op_ret:  repeat (row.reps) run_retire(1'b0);
				default: run_retire(1'b1);
			endcase
		end
		waited = 0; // Retire whatever is left in flight
		while (!rq_empty && waited < wait_limit) begin
			run_retire(1'b0);
			waited++;
		end
		if (!rq_empty) begin
			other_count++;
			$display("Timed out waiting for the retire queue to empty");
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
	parameter int rq_depth = 16
) (
	input  logic                    clock,
	input  logic                    reset,
	input  rename_pkg::rename_in_t  dispatch,
	input  logic                    retire,
	input  logic                    retire_mispredict,
	output logic                    stall,
	output rename_pkg::rename_out_t renamed,
	output rename_pkg::fl_count_t   num_free,
	output logic                    rq_empty
);

	import rename_pkg::*;

	arch_reg_t     map_rs1, map_rs2, map_rd;
	phys_reg_t     prs1, prs2, prd_cur;
	phys_reg_t     head_reg, map_prd;
	logic          fl_empty, alloc, map_we;
	logic          rq_full, rq_push_valid;
	retire_entry_t rq_push;
	retire_entry_t commit;
	logic          commit_valid, recover;

	rename_stage u_rename_stage (
		.clock, .reset, .dispatch,
		.prs1, .prs2, .prd_cur, .head_reg,
		.fl_empty, .rq_full, .recover,
		.map_rs1, .map_rs2, .map_rd,
		.alloc, .map_we, .map_prd,
		.rq_push_valid, .rq_push, .stall, .renamed
	);

	// rd drives both the T_old lookup and the write address
	map_table u_map_table (
		.clock, .reset,
		.rs1(map_rs1), .rs2(map_rs2), .rd(map_rd),
		.prs1, .prs2, .prd_cur,
		.map_we, .map_rd, .map_prd,
		.commit, .commit_valid, .recover
	);

	free_list u_free_list (
		.clock, .reset, .alloc, .commit, .commit_valid, .recover,
		.head_reg, .empty(fl_empty), .num_free
	);

	retire_queue #(.rq_depth(rq_depth)) u_retire_queue (
		.clock, .reset,
		.push_valid(rq_push_valid), .push(rq_push),
		.retire, .retire_mispredict,
		.commit, .commit_valid, .recover,
		.full(rq_full), .empty(rq_empty)
	);

endmodule

`default_nettype wire

/* rename/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  rename_pkg::rename_in_t    dispatch,
	input  rename_pkg::phys_reg_t     prs1,      // From map lookup
	input  rename_pkg::phys_reg_t     prs2,
	input  rename_pkg::phys_reg_t     prd_cur,
	input  rename_pkg::phys_reg_t     head_reg,  // Next free physical reg
	input  logic                      fl_empty,
	input  logic                      rq_full,
	input  logic                      recover,
	output rename_pkg::arch_reg_t     map_rs1,
	output rename_pkg::arch_reg_t     map_rs2,
	output rename_pkg::arch_reg_t     map_rd,
	output logic                      alloc,
	output logic                      map_we,
	output rename_pkg::phys_reg_t     map_prd,
	output logic                      rq_push_valid,
	output rename_pkg::retire_entry_t rq_push,
	output logic                      stall,
	output rename_pkg::rename_out_t   renamed
);

	import rename_pkg::*;

	logic        fire;        // Instruction actually renamed this cycle
	phys_reg_t   new_prd;
	phys_reg_t   old_prd;

	// Structural hazards, no-dest instructions skip the free-list check
	assign stall = dispatch.valid &&
		((dispatch.has_dest && fl_empty) || rq_full);

	// Recovery drops a same-cycle dispatch
	assign fire = dispatch.valid && !stall && !recover;

	assign map_rs1 = dispatch.rs1;
	assign map_rs2 = dispatch.rs2;
	assign map_rd  = dispatch.rd;

	assign new_prd = dispatch.has_dest ? head_reg : '0;
	assign old_prd = dispatch.has_dest ? prd_cur  : '0;

	assign alloc   = fire && dispatch.has_dest;
	assign map_we  = alloc;      // New mapping goes in with the pop
	assign map_prd = head_reg;

	// Every renamed instruction enters the retire queue to keep order
	assign rq_push_valid    = fire;
	assign rq_push.has_dest = dispatch.has_dest;
	assign rq_push.rd       = dispatch.rd;
	assign rq_push.prd      = new_prd;
	assign rq_push.prd_old  = old_prd;

	// Pipeline register
	always_ff @(posedge clock) begin
		if (reset) begin
			renamed.valid <= 1'b0;
		end else begin
			renamed.valid <= fire; // Squashed by recover through fire
			if (fire) begin
				renamed.has_dest <= dispatch.has_dest;
				renamed.prs1     <= prs1;
				renamed.prs2     <= prs2;
				renamed.prd      <= new_prd;
				renamed.prd_old  <= old_prd;
			end
		end
	end

endmodule

`default_nettype wire

/* rename/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module map_table (
	input  logic                      clock,
	input  logic                      reset,
	input  rename_pkg::arch_reg_t     rs1,
	input  rename_pkg::arch_reg_t     rs2,
	input  rename_pkg::arch_reg_t     rd,
	output rename_pkg::phys_reg_t     prs1,
	output rename_pkg::phys_reg_t     prs2,
	output rename_pkg::phys_reg_t     prd_cur,   // Current mapping of rd, becomes T_old
	input  logic                      map_we,
	input  rename_pkg::arch_reg_t     map_rd,
	input  rename_pkg::phys_reg_t     map_prd,
	input  rename_pkg::retire_entry_t commit,
	input  logic                      commit_valid,
	input  logic                      recover
);

	import rename_pkg::*;

	phys_reg_t spec_map [num_arch_reg]; // Rename view
	phys_reg_t ret_map  [num_arch_reg]; // Architectural view at retirement

	logic      commit_we;

	assign commit_we = commit_valid && commit.has_dest;

	// Lookups are combinational
	assign prs1    = spec_map[rs1];
	assign prs2    = spec_map[rs2];
	assign prd_cur = spec_map[rd];

	// Speculative map
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_arch_reg; i++)
				spec_map[i] <= phys_reg_t'(i); // Identity mapping
		end else if (recover) begin
			// Back to the retired state, this cycle's commit included
			for (int i = 0; i < num_arch_reg; i++)
				spec_map[i] <= ret_map[i];
			if (commit_we)
				spec_map[commit.rd] <= commit.prd;
		end else if (map_we) begin
			spec_map[map_rd] <= map_prd;
		end
	end

	// Retirement map
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_arch_reg; i++)
				ret_map[i] <= phys_reg_t'(i);
		end else if (commit_we) begin
			ret_map[commit.rd] <= commit.prd;
		end
	end

	// T_old recorded at rename must be what retirement held for rd
	a_told_match: assert property (@(posedge clock) disable iff (reset)
		commit_we |-> commit.prd_old == ret_map[commit.rd])
		else $error("map_table: prd_old %0h differs from retired map %0h for rd %0h",
			commit.prd_old, ret_map[commit.rd], commit.rd);

endmodule

`default_nettype wire

/* rename/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      alloc,        // Pop head for a new dest
	input  rename_pkg::retire_entry_t commit,       // Retiring instruction
	input  logic                      commit_valid,
	input  logic                      recover,      // Mispredicted retire
	output rename_pkg::phys_reg_t     head_reg,
	output logic                      empty,
	output rename_pkg::fl_count_t     num_free
);

	import rename_pkg::*;

	localparam int fl_idx_w = $clog2(fl_size);

	// Live list, circular with head and count
	phys_reg_t             fl_mem [fl_size];
	logic [fl_idx_w-1:0]   head;
	fl_count_t             count;
	logic [fl_idx_w-1:0]   tail_idx;

	// Retirement checkpoint
	// Always full, since each commit pops T_new and pushes T_old
	phys_reg_t             ck_mem [fl_size];
	logic [fl_idx_w-1:0]   ck_head;

	logic                  push;

	assign push     = commit_valid && commit.has_dest;
	assign tail_idx = head + count[fl_idx_w-1:0]; // Wraps, fl_size is a power of two
	assign head_reg = fl_mem[head];
	assign empty    = (count == '0);
	assign num_free = count;

	// Live list pointers
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			count <= fl_count_t'(fl_size);
		end else if (recover) begin
			head  <= ck_head + (push ? 1'b1 : 1'b0); // Post-commit checkpoint head
			count <= fl_count_t'(fl_size);
		end else begin
			if (alloc)
				head <= head + 1'b1;
			if (push && !alloc)
				count <= count + 1'b1;
			else if (alloc && !push)
				count <= count - 1'b1;
		end
	end

	// Live list storage
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < fl_size; i++)
				fl_mem[i] <= phys_reg_t'(num_arch_reg + i);
		end else if (recover) begin
			for (int i = 0; i < fl_size; i++)
				fl_mem[i] <= ck_mem[i];
			// Same-cycle commit lands in the restored copy too
			if (push)
				fl_mem[ck_head] <= commit.prd_old;
		end else if (push) begin
			fl_mem[tail_idx] <= commit.prd_old; // T_old to the tail
		end
	end

	// Checkpoint sees retired ops only
	always_ff @(posedge clock) begin
		if (reset) begin
			ck_head <= '0;
			for (int i = 0; i < fl_size; i++)
				ck_mem[i] <= phys_reg_t'(num_arch_reg + i);
		end else if (push) begin
			// Pop T_new and push T_old into the slot it leaves
			ck_mem[ck_head] <= commit.prd_old;
			ck_head         <= ck_head + 1'b1;
		end
	end

	// In-order alloc and retire keep the checkpoint head equal to T_new
	a_ck_order: assert property (@(posedge clock) disable iff (reset)
		push |-> ck_mem[ck_head] == commit.prd)
		else $error("free_list: checkpoint head %0h differs from committed prd %0h",
			ck_mem[ck_head], commit.prd);

	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		(push && !alloc && !recover) |-> count != fl_count_t'(fl_size))
		else $error("free_list: push while full");

	// Stall logic must keep alloc away from an empty list
	a_no_underflow: assert property (@(posedge clock) disable iff (reset)
		alloc |-> !empty)
		else $error("free_list: alloc while empty");

endmodule

`default_nettype wire

/* src/retire_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_queue #(
	parameter int rq_depth = 16
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      push_valid,
	input  rename_pkg::retire_entry_t push,
	input  logic                      retire,             // One-cycle strobe
	input  logic                      retire_mispredict,  // Sampled with retire
	output rename_pkg::retire_entry_t commit,
	output logic                      commit_valid,
	output logic                      recover,
	output logic                      full,
	output logic                      empty
);

	import rename_pkg::*;

	localparam int idx_w = (rq_depth > 1) ? $clog2(rq_depth) : 1;
	localparam int cnt_w = $clog2(rq_depth + 1);

	retire_entry_t      mem [rq_depth]; // Program-order entries
	logic [idx_w-1:0]   head;
	logic [idx_w-1:0]   tail;
	logic [cnt_w-1:0]   count;
	logic               pop;

	assign full  = (count == cnt_w'(rq_depth));
	assign empty = (count == '0);

	// Retire on an empty queue does nothing
	assign pop          = retire && !empty;
	assign commit       = mem[head];
	assign commit_valid = pop;
	assign recover      = pop && retire_mispredict;

	// Control
	always_ff @(posedge clock) begin
		if (reset || recover) begin
			// Flush on mispredict, younger entries are wrong path
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push_valid)
				tail <= (tail == idx_w'(rq_depth - 1)) ? '0 : tail + 1'b1;
			if (pop)
				head <= (head == idx_w'(rq_depth - 1)) ? '0 : head + 1'b1;
			if (push_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !push_valid)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (push_valid)
			mem[tail] <= push;
	end

	a_retire_empty: assert property (@(posedge clock) disable iff (reset)
		retire |-> !empty)
		else $error("retire_queue: retire strobe with empty queue");

	// Rename must stall on full
	a_push_full: assert property (@(posedge clock) disable iff (reset)
		push_valid |-> (!full || pop))
		else $error("retire_queue: push while full");

endmodule

`default_nettype wire

/* common/rename_pkg.sv */
`default_nettype none

package rename_pkg;

	// Register file sizing
	localparam int num_arch_reg = 32;
	localparam int num_phys_reg = 64;
	localparam int fl_size      = num_phys_reg - num_arch_reg; // Regs not holding arch state

	typedef logic [$clog2(num_arch_reg)-1:0] arch_reg_t;  // 5 bits
	typedef logic [$clog2(num_phys_reg)-1:0] phys_reg_t;  // 6 bits
	typedef logic [$clog2(fl_size+1)-1:0]    fl_count_t;  // 0 to fl_size

	// Decoded instruction entering rename
	typedef struct packed {
		logic      valid;
		logic      has_dest;
		logic      is_branch;
		arch_reg_t rs1;
		arch_reg_t rs2;
		arch_reg_t rd;
	} rename_in_t;

	// Renamed instruction out of the pipeline register
	typedef struct packed {
		logic      valid;
		logic      has_dest;
		phys_reg_t prs1;
		phys_reg_t prs2;
		phys_reg_t prd;      // T_new, zero without dest
		phys_reg_t prd_old;  // T_old, zero without dest
	} rename_out_t;

	// One in-flight instruction waiting for retirement
	typedef struct packed {
		logic      has_dest;
		arch_reg_t rd;
		phys_reg_t prd;      // T_new
		phys_reg_t prd_old;  // T_old, freed at retire
	} retire_entry_t;

endpackage

`default_nettype wire
